//--- sdmacPkg.sv
// Shared SCSI DMA definitions: transfer state enum, FIFO geometry and data widths

package sdmacPkg;

    // Data widths
    localparam int WORD_W     = 32;              // Host longword
    localparam int BYTE_W     = 8;               // SCSI chip data bus

    // FIFO geometry
    localparam int FIFO_DEPTH = 8;               // Longword entries
    localparam int PTR_W      = 3;               // Next-in / next-out pointer width
    localparam int CNT_W      = 4;               // Entry count, holds 0..FIFO_DEPTH

    // SCSI transfer state machine states
    typedef enum logic [2:0] {
        IDLE     = 3'd0,                         // Waiting for CPU request or DREQ
        CPU_ACC  = 3'd1,                         // Chip select with RE or WE, two cycles
        CPU_TERM = 3'd2,                         // CPU cycle terminated, wait for AS low
        DMA_XFER = 3'd3,                         // Recheck DREQ and FIFO, then issue DACK
        DMA_REC  = 3'd4                          // Recovery, DACK pulse on the bus
    } scsiState;

    // Byte 0 of a longword sits in bits 31..24
    // Lane index inside the FIFO entry is (3 - byte pointer)

endpackage

//--- scsiSm.sv
// SCSI transfer state machine: CPU register access and DMA byte moves with DREQ/DACK

`timescale 1ns/1ps

module scsiSm (
    input  logic                        BCLK,
    input  logic                        CRESET_,
    // CPU side
    input  logic                        cpuReq_i,      // CPU wants a chip register
    input  logic                        cpuAs_i,       // Address strobe, high active
    input  logic                        cpuRw_i,       // 1 = read
    input  logic [sdmacPkg::BYTE_W-1:0] cpuWrData_i,
    // DMA control
    input  logic                        dmaEn_i,
    input  logic                        dmaDir_i,      // 0 = SCSI to memory
    // SCSI chip side
    input  logic                        dreqN_i,       // Low while chip has or wants a byte
    input  logic [sdmacPkg::BYTE_W-1:0] scsiDataIn_i,
    // FIFO status
    input  logic                        boEq3_i,       // Byte pointer at last lane
    input  logic                        fifoEmpty_i,
    input  logic                        fifoFull_i,
    input  logic [sdmacPkg::BYTE_W-1:0] outByte_i,     // FIFO byte at current pointer
    // Registered outputs
    output logic                        scsiCs_o,
    output logic                        re_o,
    output logic                        we_o,
    output logic                        dack_o,
    output logic                        ls2Cpu_o,      // CPU cycle termination
    output logic                        incBo_o,
    output logic                        incNi_o,
    output logic                        incNo_o,
    output logic                        lByte_o,
    output logic [sdmacPkg::BYTE_W-1:0] scsiDataOut_o,
    output logic [sdmacPkg::BYTE_W-1:0] cpuRdData_o
);

    sdmacPkg::scsiState state;
    sdmacPkg::scsiState stateNext;

    logic cpuReqS;                                      // Sampled CPU request
    logic dreqNS;                                       // Sampled DREQ, active low
    logic accCnt;                                       // Second cycle of CPU_ACC
    logic accCntNext;
    logic dmaReady;

    // Next values of the registered outputs
    logic csNext;
    logic reNext;
    logic weNext;
    logic dackNext;
    logic incBoNext;
    logic incNiNext;
    logic incNoNext;
    logic lByteNext;
    logic termSet;                                      // Raise ls2Cpu
    logic loadWr;                                       // CPU write data onto SCSI bus
    logic loadOut;                                      // FIFO byte onto SCSI bus
    logic loadRd;                                       // Latch chip data for CPU

    // Input synchronizers, one stage each
    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            cpuReqS <= 1'b0;
            dreqNS  <= 1'b1;                            // DREQ idle high
        end else begin
            cpuReqS <= cpuReq_i;
            dreqNS  <= dreqN_i;
        end
    end

    // Byte can move now: DREQ seen and room or data in the FIFO
    // Toward memory a full FIFO always has its byte pointer back at 0
    assign dmaReady = dmaEn_i && !dreqNS && (dmaDir_i ? !fifoEmpty_i : !fifoFull_i);

    always_comb begin
        stateNext  = state;
        accCntNext = accCnt;
        csNext     = 1'b0;
        reNext     = 1'b0;
        weNext     = 1'b0;
        dackNext   = 1'b0;
        incBoNext  = 1'b0;
        incNiNext  = 1'b0;
        incNoNext  = 1'b0;
        lByteNext  = 1'b0;
        termSet    = 1'b0;
        loadWr     = 1'b0;
        loadOut    = 1'b0;
        loadRd     = 1'b0;
        case (state)
            sdmacPkg::IDLE: begin
                if (cpuReqS && cpuAs_i && !ls2Cpu_o) begin   // CPU wins over DREQ
                    stateNext  = sdmacPkg::CPU_ACC;
                    csNext     = 1'b1;
                    reNext     = cpuRw_i;
                    weNext     = !cpuRw_i;
                    loadWr     = !cpuRw_i;
                    accCntNext = 1'b0;
                end else if (dmaReady) begin
                    stateNext = sdmacPkg::DMA_XFER;
                end
            end
            sdmacPkg::CPU_ACC: begin
                if (!accCnt) begin                      // Hold strobes one more cycle
                    csNext     = 1'b1;
                    reNext     = re_o;
                    weNext     = we_o;
                    accCntNext = 1'b1;
                end else begin
                    stateNext = sdmacPkg::CPU_TERM;
                    termSet   = 1'b1;
                    loadRd    = re_o;                   // Chip data valid while RE high
                end
            end
            sdmacPkg::CPU_TERM: begin
                if (!cpuAs_i) stateNext = sdmacPkg::IDLE;   // CPU ended its cycle
            end
            sdmacPkg::DMA_XFER: begin
                // DREQ may have been released meanwhile
                if (dmaReady) begin
                    stateNext = sdmacPkg::DMA_REC;
                    dackNext  = 1'b1;
                    incBoNext = 1'b1;
                    if (dmaDir_i) begin                 // FIFO to SCSI
                        weNext    = 1'b1;
                        incNoNext = boEq3_i;            // Last lane retires the entry
                        loadOut   = 1'b1;
                    end else begin                      // SCSI to FIFO
                        reNext    = 1'b1;
                        lByteNext = 1'b1;
                        incNiNext = boEq3_i;            // Last lane completes the entry
                    end
                end else begin
                    stateNext = sdmacPkg::IDLE;
                end
            end
            sdmacPkg::DMA_REC: stateNext = sdmacPkg::IDLE;   // One idle cycle per byte
            default: stateNext = sdmacPkg::IDLE;
        endcase
    end

    // State and control outputs
    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            state    <= sdmacPkg::IDLE;
            accCnt   <= 1'b0;
            scsiCs_o <= 1'b0;
            re_o     <= 1'b0;
            we_o     <= 1'b0;
            dack_o   <= 1'b0;
            incBo_o  <= 1'b0;
            incNi_o  <= 1'b0;
            incNo_o  <= 1'b0;
            lByte_o  <= 1'b0;
            ls2Cpu_o <= 1'b0;
        end else begin
            state    <= stateNext;
            accCnt   <= accCntNext;
            scsiCs_o <= csNext;
            re_o     <= reNext;
            we_o     <= weNext;
            dack_o   <= dackNext;
            incBo_o  <= incBoNext;
            incNi_o  <= incNiNext;
            incNo_o  <= incNoNext;
            lByte_o  <= lByteNext;
            ls2Cpu_o <= (termSet | ls2Cpu_o) & cpuAs_i;  // Held until AS drops
        end
    end

    // Data paths
    always_ff @(posedge BCLK) begin
        if (loadWr) scsiDataOut_o <= cpuWrData_i;
        else if (loadOut) scsiDataOut_o <= outByte_i;
        if (loadRd) cpuRdData_o <= scsiDataIn_i;
    end

endmodule

//--- dmaFifo.sv
// Longword DMA FIFO: byte pointer, big-endian byte lanes, host push/pop and count flags

`timescale 1ns/1ps

module dmaFifo (
    input  logic                        BCLK,
    input  logic                        CRESET_,
    // SCSI side
    input  logic [sdmacPkg::BYTE_W-1:0] scsiByte_i,    // Byte from the chip
    input  logic                        lByte_i,       // Load byte into current lane
    input  logic                        incBo_i,       // Step byte pointer
    input  logic                        incNi_i,       // Entry complete from SCSI
    input  logic                        incNo_i,       // Entry drained to SCSI
    // Host side
    input  logic                        hostPush_i,    // Whole longword in
    input  logic [sdmacPkg::WORD_W-1:0] pushWord_i,
    input  logic                        hostPop_i,     // Head longword out
    // Status and data
    output logic                        boEq3_o,
    output logic                        fifoEmpty_o,
    output logic                        fifoFull_o,
    output logic [sdmacPkg::BYTE_W-1:0] outByte_o,
    output logic [sdmacPkg::WORD_W-1:0] headWord_o
);

    localparam int LANES = sdmacPkg::WORD_W / sdmacPkg::BYTE_W;

    // Entries split into byte lanes, lane 3 is byte 0
    logic [LANES-1:0][sdmacPkg::BYTE_W-1:0] fifoMem [sdmacPkg::FIFO_DEPTH];

    logic [sdmacPkg::PTR_W-1:0] nextIn;
    logic [sdmacPkg::PTR_W-1:0] nextOut;
    logic [sdmacPkg::CNT_W-1:0] count;
    logic [1:0]                 bytePtr;                // Shared by both directions
    logic [1:0]                 laneIdx;
    logic                       push;
    logic                       pop;

    assign push    = incNi_i | hostPush_i;
    assign pop     = incNo_i | hostPop_i;
    assign laneIdx = 2'd3 - bytePtr;                    // Big-endian lane select

    // Pointers and count
    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            nextIn  <= '0;
            nextOut <= '0;
            count   <= '0;
            bytePtr <= 2'd0;
        end else begin
            if (push) nextIn <= nextIn + 1'b1;          // Wraps at depth
            if (pop) nextOut <= nextOut + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                // Both or neither
            endcase
            if (incBo_i) bytePtr <= bytePtr + 1'b1;     // 3 wraps back to 0
        end
    end

    // Storage
    always_ff @(posedge BCLK) begin
        if (hostPush_i) begin
            fifoMem[nextIn] <= pushWord_i;              // Whole longword from memory
        end else if (lByte_i) begin
            fifoMem[nextIn][laneIdx] <= scsiByte_i;     // One lane from the chip
        end
    end

    // Read side, all from the head entry
    assign headWord_o = fifoMem[nextOut];
    assign outByte_o  = fifoMem[nextOut][laneIdx];

    // Flags
    assign boEq3_o     = (bytePtr == 2'd3);
    assign fifoEmpty_o = (count == '0);
    assign fifoFull_o  = (count == sdmacPkg::CNT_W'(sdmacPkg::FIFO_DEPTH));

endmodule

//--- hostPort.sv
// Host memory port: moves whole longwords between the FIFO and a req/ack memory bus

`timescale 1ns/1ps

module hostPort (
    input  logic                        BCLK,
    input  logic                        CRESET_,
    input  logic                        dmaEn_i,
    input  logic                        dmaDir_i,      // 0 = FIFO drains to memory
    input  logic                        fifoEmpty_i,
    input  logic                        fifoFull_i,
    input  logic [sdmacPkg::WORD_W-1:0] headWord_i,    // Oldest FIFO longword
    input  logic [sdmacPkg::WORD_W-1:0] memRdData_i,
    input  logic                        memAck_i,      // Ends the memory cycle
    output logic                        memReq_o,      // Also the busy state
    output logic                        memWr_o,
    output logic [sdmacPkg::WORD_W-1:0] memWrData_o,
    output logic                        hostPush_o,
    output logic                        hostPop_o,
    output logic [sdmacPkg::WORD_W-1:0] pushWord_o
);

    logic startWr;
    logic startRd;
    logic settle;                                       // FIFO flags still catching up

    assign settle  = hostPush_o | hostPop_o;
    assign startWr = !memReq_o && !settle && dmaEn_i && !dmaDir_i && !fifoEmpty_i;
    assign startRd = !memReq_o && !settle && dmaEn_i && dmaDir_i && !fifoFull_i;

    // Idle / request state and FIFO strobes
    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            memReq_o   <= 1'b0;
            memWr_o    <= 1'b0;
            hostPush_o <= 1'b0;
            hostPop_o  <= 1'b0;
        end else begin
            hostPush_o <= 1'b0;
            hostPop_o  <= 1'b0;
            if (memReq_o) begin
                if (memAck_i) begin                     // Longword done
                    memReq_o   <= 1'b0;
                    hostPop_o  <= memWr_o;
                    hostPush_o <= !memWr_o;
                end
            end else if (startWr) begin
                memReq_o <= 1'b1;
                memWr_o  <= 1'b1;
            end else if (startRd) begin
                memReq_o <= 1'b1;
                memWr_o  <= 1'b0;
            end
        end
    end

    // Longword holding registers
    always_ff @(posedge BCLK) begin
        if (startWr) memWrData_o <= headWord_i;         // Stable for the whole request
        if (memReq_o && memAck_i && !memWr_o) pushWord_o <= memRdData_i;
    end

endmodule

//--- sdmacScsiTop.sv
// SCSI DMA top level: transfer state machine, longword FIFO and host memory port

`timescale 1ns/1ps

module sdmacScsiTop (
    input  logic                        BCLK,
    input  logic                        CRESET_,
    // SCSI chip side
    input  logic                        dreqN_i,
    input  logic [sdmacPkg::BYTE_W-1:0] scsiDataIn_i,
    output logic                        dack_o,
    output logic                        re_o,
    output logic                        we_o,
    output logic                        scsiCs_o,
    output logic [sdmacPkg::BYTE_W-1:0] scsiDataOut_o,
    // CPU side
    input  logic                        cpuReq_i,
    input  logic                        cpuAs_i,
    input  logic                        cpuRw_i,
    input  logic [sdmacPkg::BYTE_W-1:0] cpuWrData_i,
    output logic [sdmacPkg::BYTE_W-1:0] cpuRdData_o,
    output logic                        ls2Cpu_o,
    // DMA control
    input  logic                        dmaEn_i,
    input  logic                        dmaDir_i,
    // Memory side
    output logic                        memReq_o,
    output logic                        memWr_o,
    output logic [sdmacPkg::WORD_W-1:0] memWrData_o,
    input  logic [sdmacPkg::WORD_W-1:0] memRdData_i,
    input  logic                        memAck_i
);

    // State machine to FIFO
    logic incBo;
    logic incNi;
    logic incNo;
    logic lByte;
    // FIFO status
    logic boEq3;
    logic fifoEmpty;
    logic fifoFull;
    logic [sdmacPkg::BYTE_W-1:0] outByte;
    logic [sdmacPkg::WORD_W-1:0] headWord;
    // Host port to FIFO
    logic hostPush;
    logic hostPop;
    logic [sdmacPkg::WORD_W-1:0] pushWord;

    scsiSm uScsiSm (
        .BCLK(BCLK), .CRESET_(CRESET_),
        .cpuReq_i(cpuReq_i), .cpuAs_i(cpuAs_i), .cpuRw_i(cpuRw_i), .cpuWrData_i(cpuWrData_i),
        .dmaEn_i(dmaEn_i), .dmaDir_i(dmaDir_i),
        .dreqN_i(dreqN_i), .scsiDataIn_i(scsiDataIn_i),
        .boEq3_i(boEq3), .fifoEmpty_i(fifoEmpty), .fifoFull_i(fifoFull), .outByte_i(outByte),
        .scsiCs_o(scsiCs_o), .re_o(re_o), .we_o(we_o), .dack_o(dack_o), .ls2Cpu_o(ls2Cpu_o),
        .incBo_o(incBo), .incNi_o(incNi), .incNo_o(incNo), .lByte_o(lByte),
        .scsiDataOut_o(scsiDataOut_o), .cpuRdData_o(cpuRdData_o)
    );

    dmaFifo uDmaFifo (
        .BCLK(BCLK), .CRESET_(CRESET_),
        .scsiByte_i(scsiDataIn_i), .lByte_i(lByte),    // Chip data straight into the lane
        .incBo_i(incBo), .incNi_i(incNi), .incNo_i(incNo),
        .hostPush_i(hostPush), .pushWord_i(pushWord), .hostPop_i(hostPop),
        .boEq3_o(boEq3), .fifoEmpty_o(fifoEmpty), .fifoFull_o(fifoFull),
        .outByte_o(outByte), .headWord_o(headWord)
    );

    hostPort uHostPort (
        .BCLK(BCLK), .CRESET_(CRESET_),
        .dmaEn_i(dmaEn_i), .dmaDir_i(dmaDir_i),
        .fifoEmpty_i(fifoEmpty), .fifoFull_i(fifoFull), .headWord_i(headWord),
        .memRdData_i(memRdData_i), .memAck_i(memAck_i),
        .memReq_o(memReq_o), .memWr_o(memWr_o), .memWrData_o(memWrData_o),
        .hostPush_o(hostPush), .hostPop_o(hostPop), .pushWord_o(pushWord)
    );

endmodule

//--- sdmacScsiChecker.sv
// Bound assertions on the SCSI state machine for strobe exclusivity and pulse shapes

`timescale 1ns/1ps

module sdmacScsiChecker (
    input logic BCLK,
    input logic CRESET_,
    input logic dack_o,
    input logic scsiCs_o,
    input logic re_o,
    input logic we_o,
    input logic ls2Cpu_o,
    input logic cpuAs_i
);

    // DMA and register access never share the bus
    dackVsCs: assert property (@(posedge BCLK) disable iff (!CRESET_)
        !(dack_o && scsiCs_o))
        else $error("dack_o and scsiCs_o high together");

    rdVsWr: assert property (@(posedge BCLK) disable iff (!CRESET_)
        !(re_o && we_o))
        else $error("re_o and we_o high together");

    // One byte per DACK
    dackPulse: assert property (@(posedge BCLK) disable iff (!CRESET_)
        dack_o |=> !dack_o)
        else $error("dack_o longer than one cycle");

    // Termination released one cycle after AS drops
    termRelease: assert property (@(posedge BCLK) disable iff (!CRESET_)
        ($fell(cpuAs_i) && ls2Cpu_o) |=> !ls2Cpu_o)
        else $error("ls2Cpu_o held after cpuAs_i fell");

endmodule

bind scsiSm sdmacScsiChecker uChecker (
    .BCLK(BCLK), .CRESET_(CRESET_), .dack_o(dack_o), .scsiCs_o(scsiCs_o),
    .re_o(re_o), .we_o(we_o), .ls2Cpu_o(ls2Cpu_o), .cpuAs_i(cpuAs_i)
);

//--- tbSdmacScsi.sv
// Testbench for the SCSI DMA top with clock, reset, watchdog, chip and memory models and checks

`timescale 1ns/1ps

module tbSdmacScsi;

    logic                        BCLK, CRESET_;
    logic                        dreqN_i, dack_o, re_o, we_o, scsiCs_o;
    logic [sdmacPkg::BYTE_W-1:0] scsiDataIn_i, scsiDataOut_o;
    logic                        cpuReq_i, cpuAs_i, cpuRw_i, ls2Cpu_o;
    logic [sdmacPkg::BYTE_W-1:0] cpuWrData_i, cpuRdData_o;
    logic                        dmaEn_i, dmaDir_i;
    logic                        memReq_o, memWr_o, memAck_i;
    logic [sdmacPkg::WORD_W-1:0] memWrData_o, memRdData_i;

    int seed = 1;
    int mismatches = 0;
    int failures = 0;
    int totalBytes = 64 + 64 + 96 + 48;                 // Sum of all DMA test lengths

    // Models
    logic [sdmacPkg::BYTE_W-1:0] stream [256];          // SCSI byte stream, toward memory
    logic [sdmacPkg::WORD_W-1:0] memWords [64];         // Memory contents, toward SCSI
    logic [sdmacPkg::BYTE_W-1:0] chipRegs [8];
    logic [sdmacPkg::BYTE_W-1:0] regModel [8];          // Expected register contents
    int  nBytes, nWords, inIdx, outIdx, wrIdx, rdIdx, memDone, waitCnt, maxFill;
    int  cpuAddr = 0;
    int  accesses = 0;
    int  terms = 0;
    bit  slowMem = 0;
    logic ls2Prev = 1'b0;

    sdmacScsiTop dut (.*);

    initial begin
        BCLK = 1'b0;
        forever #20 BCLK = ~BCLK;
    end

    initial begin
        repeat (totalBytes * 40 + 2000) @(posedge BCLK);
        $display("Watchdog expired before the tests completed");
        $display("Simulation FAILED");
        $finish;
    end

    task automatic byteCompare(input string name, input logic [sdmacPkg::BYTE_W-1:0] got,
                               input logic [sdmacPkg::BYTE_W-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic wordCompare(input string name, input logic [sdmacPkg::WORD_W-1:0] got,
                               input logic [sdmacPkg::WORD_W-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic flagCompare(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // SCSI chip model with register file, byte stream source and sink, and DREQ
    always @(posedge BCLK) begin
        logic dackS, reS, weS, csS;
        logic [sdmacPkg::BYTE_W-1:0] dOutS, wrS;
        logic [sdmacPkg::WORD_W-1:0] word;
        int doneS, fill;
        dackS = dack_o;                                 // Values of the cycle just ended
        reS   = re_o;
        weS   = we_o;
        csS   = scsiCs_o;
        dOutS = scsiDataOut_o;
        wrS   = cpuWrData_i;
        doneS = memDone;
        #2;
        if (csS && weS) begin                           // CPU register write
            byteCompare("scsiDataOut_o", dOutS, wrS);
            chipRegs[cpuAddr] = dOutS;
        end
        if (dackS && reS) begin                         // Byte taken toward memory
            if (inIdx >= nBytes) begin
                failures++;
                $display("Extra dack_o after the last SCSI byte at %0t", $time);
            end
            fill = inIdx / 4 - doneS;
            if (inIdx % 4 == 0 && fill >= sdmacPkg::FIFO_DEPTH) begin
                failures++;
                $display("dack_o issued while the FIFO was full at %0t", $time);
            end
            if (inIdx % 4 == 3 && fill + 1 > maxFill) maxFill = fill + 1;
            inIdx++;
        end
        if (dackS && weS) begin                         // Byte delivered toward SCSI
            if (outIdx >= nBytes) begin
                failures++;
                $display("Extra dack_o after the last memory byte at %0t", $time);
            end else begin
                word = memWords[outIdx / 4];
                byteCompare("scsiDataOut_o", dOutS, word[31 - 8 * (outIdx % 4) -: 8]);
            end
            outIdx++;
        end
        scsiDataIn_i = scsiCs_o ? chipRegs[cpuAddr] : stream[inIdx % 256];
        // DREQ dropped now and then to exercise the recheck
        dreqN_i = !(dmaEn_i && ((dmaDir_i ? outIdx : inIdx) < nBytes)
                    && ($unsigned($random(seed)) % 8 != 0));
    end

    // Memory model with random or long acknowledge delay
    always @(posedge BCLK) begin
        logic reqS, wrS, ackS;
        logic [sdmacPkg::WORD_W-1:0] dataS;
        reqS  = memReq_o;
        wrS   = memWr_o;
        ackS  = memAck_i;
        dataS = memWrData_o;
        #2;
        if (reqS && ackS) begin                         // Longword done
            memAck_i = 1'b0;
            if (wrS) begin
                if (wrIdx < nWords)
                    wordCompare("memWrData_o", dataS, {stream[4 * wrIdx], stream[4 * wrIdx + 1],
                                stream[4 * wrIdx + 2], stream[4 * wrIdx + 3]});
                else begin
                    failures++;
                    $display("Unexpected memory write at %0t", $time);
                end
                wrIdx++;
            end
            memDone++;
            waitCnt = slowMem ? 30 : $unsigned($random(seed)) % 7;
        end else if (reqS) begin
            if (waitCnt == 0) begin
                memAck_i = 1'b1;
                if (!wrS) begin
                    memRdData_i = memWords[rdIdx % 64];  // Prefetch past the end is harmless
                    rdIdx++;
                end
            end else waitCnt--;
        end
    end

    // Termination count
    always @(posedge BCLK) begin
        if (ls2Cpu_o && !ls2Prev) terms++;
        ls2Prev = ls2Cpu_o;
    end

    task automatic applyReset();
        @(posedge BCLK);
        #2;
        CRESET_  = 1'b0;
        dmaEn_i  = 1'b0;
        memAck_i = 1'b0;
        inIdx = 0;
        outIdx = 0;
        wrIdx = 0;
        rdIdx = 0;
        memDone = 0;
        waitCnt = 0;
        maxFill = 0;
        repeat (5) @(posedge BCLK);
        #2 CRESET_ = 1'b1;
    endtask

    task automatic cpuAccess(input logic rw, input int addr);
        logic [sdmacPkg::BYTE_W-1:0] wdata;
        int cnt;
        wdata = $random(seed);
        cnt = 0;
        @(posedge BCLK);
        #2;
        cpuAddr = addr;
        cpuRw_i = rw;
        cpuWrData_i = wdata;
        cpuReq_i = 1'b1;
        cpuAs_i = 1'b1;
        do begin
            @(posedge BCLK);
            cnt++;
        end while (!ls2Cpu_o && cnt < 200);
        if (!ls2Cpu_o) begin
            failures++;
            $display("CPU access was never terminated at %0t", $time);
        end else if (rw) byteCompare("cpuRdData_o", cpuRdData_o, regModel[addr]);
        else regModel[addr] = wdata;
        #2;
        cpuReq_i = 1'b0;
        cpuAs_i = 1'b0;
        accesses++;
        repeat (2) @(posedge BCLK);
    endtask

    task automatic waitDma();
        int cnt;
        cnt = 0;
        while ((dmaDir_i ? outIdx < nBytes : wrIdx < nWords) && cnt < nBytes * 40) begin
            @(posedge BCLK);
            cnt++;
        end
        if (cnt >= nBytes * 40) begin
            failures++;
            $display("DMA transfer did not complete at %0t", $time);
        end
    endtask

    task automatic runDma(input logic dir, input int bytes, input bit slow, input bit cpuMix);
        applyReset();
        nBytes = bytes;
        nWords = bytes / 4;
        slowMem = slow;
        foreach (stream[i]) stream[i] = $random(seed);
        foreach (memWords[i]) memWords[i] = $random(seed);
        @(posedge BCLK);
        #2;
        dmaDir_i = dir;
        dmaEn_i = 1'b1;
        fork
            waitDma();
            if (cpuMix) repeat (8) cpuAccess($random(seed), $unsigned($random(seed)) % 8);
        join
        repeat (20) @(posedge BCLK);                    // Catch stray DACKs
        #2 dmaEn_i = 1'b0;
    endtask

    initial begin
        CRESET_ = 1'b0;
        dreqN_i = 1'b1;
        scsiDataIn_i = '0;
        cpuReq_i = 1'b0;
        cpuAs_i = 1'b0;
        cpuRw_i = 1'b0;
        cpuWrData_i = '0;
        dmaEn_i = 1'b0;
        dmaDir_i = 1'b0;
        memRdData_i = '0;
        memAck_i = 1'b0;
        nBytes = 0;
        nWords = 0;
        for (int i = 0; i < 8; i++) begin
            chipRegs[i] = $random(seed);
            regModel[i] = chipRegs[i];
        end
        applyReset();
        @(posedge BCLK);
        flagCompare("dack_o", dack_o, 1'b0);
        flagCompare("re_o", re_o, 1'b0);
        flagCompare("we_o", we_o, 1'b0);
        flagCompare("scsiCs_o", scsiCs_o, 1'b0);
        flagCompare("ls2Cpu_o", ls2Cpu_o, 1'b0);
        flagCompare("memReq_o", memReq_o, 1'b0);
        flagCompare("fifoEmpty", dut.uDmaFifo.fifoEmpty_o, 1'b1);
        repeat (20) cpuAccess($random(seed), $unsigned($random(seed)) % 8);
        runDma(1'b0, 64, 1'b0, 1'b0);                   // SCSI to memory
        runDma(1'b1, 64, 1'b0, 1'b0);                   // Memory to SCSI
        runDma(1'b0, 96, 1'b1, 1'b0);                   // Slow memory fills the FIFO
        if (maxFill < sdmacPkg::FIFO_DEPTH) begin
            failures++;
            $display("FIFO never filled during the slow memory test");
        end
        runDma(1'b0, 48, 1'b0, 1'b1);                   // CPU cycles mixed into DMA
        if (terms != accesses) begin
            failures++;
            $display("Saw %0d terminations for %0d CPU accesses", terms, accesses);
        end
        $display("Checks done: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- sdmacScsi.f
sdmacPkg.sv
scsiSm.sv
dmaFifo.sv
hostPort.sv
sdmacScsiTop.sv
sdmacScsiChecker.sv
tbSdmacScsi.sv

//--- Bender.yml
package:
  name: sdmacScsi

sources:
  - sdmacPkg.sv
  - scsiSm.sv
  - dmaFifo.sv
  - hostPort.sv
  - sdmacScsiTop.sv
  - target: test
    files:
      - sdmacScsiChecker.sv
      - tbSdmacScsi.sv
